// ==== Makefile ====
# Verilator build and run for the DMA write path testbench

VERILATOR ?= verilator
TOP       ?= tb_dma_write
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== axi_write_master.sv ====
/*
  AXI4 write master for one burst at a time on AW and W.
  Up to MAX_OUTSTANDING bursts may wait for their B response.
  User beats pass straight to W; the user must hold valid and data
  until usr_wready, or W breaks the AXI stability rule.
  A B with an unexpected ID is reported as DECERR.
*/
`timescale 1ns/1ps
`default_nettype none

module axi_write_master import dma_pkg::*; #(
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic       aclk,
    input  logic       arst_n,
    input  burst_cmd_t q_cmd,
    input  logic       q_valid,
    output logic       q_ready,
    input  usr_beat_t  usr_w,
    input  logic       usr_wvalid,
    output logic       usr_wready,
    output axi_aw_t    aw,
    output logic       awvalid,
    input  logic       awready,
    output axi_w_t     w,
    output logic       wvalid,
    input  logic       wready,
    input  axi_b_t     b,
    input  logic       bvalid,
    output logic       bready,
    output logic       burst_done,
    output axi_resp_t  burst_resp
);

    localparam int OUT_W = $clog2(MAX_OUTSTANDING + 1);
    localparam logic [OUT_W-1:0] OUT_MAX = OUT_W'(MAX_OUTSTANDING);

    wm_state_t        state;
    burst_cmd_t       cmd_q;
    axlen_t           beat_cnt;
    logic [OUT_W-1:0] out_cnt;

    logic             pop;
    logic             aw_hs;
    logic             w_hs;
    logic             w_last;
    logic             b_hs;

    // B is always accepted
    assign bready = 1'b1;
    assign b_hs   = bvalid & bready;

    // Pop only with room for one more outstanding burst
    assign q_ready = (state == WM_IDLE) && (out_cnt < OUT_MAX);
    assign pop     = q_valid & q_ready;

    // AW from the latched command, full-width beats, INCR
    assign awvalid = (state == WM_ADDR);
    assign aw_hs   = awvalid & awready;
    assign aw = '{
        id:    DMA_ID,
        addr:  cmd_q.addr,
        len:   cmd_q.len,
        size:  3'(BEAT_BYTES_LOG),
        burst: 2'b01
    };

    // W follows the user stream in WM_DATA
    assign w_last     = (beat_cnt == '0);
    assign wvalid     = (state == WM_DATA) & usr_wvalid;
    assign usr_wready = (state == WM_DATA) & wready;
    assign w_hs       = wvalid & wready;
    assign w = '{data: usr_w.data, strb: usr_w.strb, last: w_last};

    // Command latch
    always_ff @(posedge aclk) begin
        if (pop) begin
            cmd_q <= q_cmd;
        end
    end

    // FSM and beat countdown
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= WM_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                WM_IDLE: begin
                    if (pop) begin
                        state <= WM_ADDR;
                    end
                end
                WM_ADDR: begin
                    if (aw_hs) begin
                        state    <= WM_DATA;
                        beat_cnt <= cmd_q.len;
                    end
                end
                WM_DATA: begin
                    if (w_hs) begin
                        if (w_last) begin
                            state <= WM_IDLE;
                        end else begin
                            beat_cnt <= beat_cnt - 1'b1;
                        end
                    end
                end
                default: state <= WM_IDLE;
            endcase
        end
    end

    // Outstanding bursts, counted from pop to B
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            out_cnt <= '0;
        end else begin
            if (pop && !b_hs) begin
                out_cnt <= out_cnt + 1'b1;
            end else if (b_hs && !pop) begin
                out_cnt <= out_cnt - 1'b1;
            end
        end
    end

    // One pulse per accepted B
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            burst_done <= 1'b0;
        end else begin
            burst_done <= b_hs;
        end
    end

    // Response travels with the pulse
    always_ff @(posedge aclk) begin
        if (b_hs) begin
            burst_resp <= (b.id != DMA_ID) ? DECERR : b.resp;
        end
    end

endmodule

`default_nettype wire

// ==== burst_cmd_fifo.sv ====
/*
  Registered circular FIFO for burst commands.
  FIFO_DEPTH must be at least 2; any value, not only powers of two.
  Output shows a command one cycle after it is written.
*/
`timescale 1ns/1ps
`default_nettype none

module burst_cmd_fifo import dma_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic       aclk,
    input  logic       arst_n,
    input  burst_cmd_t wr_cmd,
    input  logic       wr_valid,
    output logic       wr_ready,
    output burst_cmd_t rd_cmd,
    output logic       rd_valid,
    input  logic       rd_ready
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);

    burst_cmd_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign wr_ready = (count != CNT_FULL);
    assign rd_valid = (count != '0);
    assign rd_cmd   = mem[rd_ptr];

    assign push = wr_valid & wr_ready;
    assign pop  = rd_valid & rd_ready;

    // Storage
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= wr_cmd;
        end
    end

    // Pointers wrap at the last entry
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== burst_splitter.sv ====
/*
  Cuts one descriptor into INCR bursts of at most BURST_BEATS beats.
  No burst crosses a window of BURST_BEATS beats, which also keeps
  every burst inside a 4 KB page for BURST_BEATS up to 256.
  Start address and length must be beat aligned; length must be nonzero.
  A new descriptor is taken only after irq_w1c has cleared irq.
*/
`timescale 1ns/1ps
`default_nettype none

module burst_splitter import dma_pkg::*; #(
    parameter int BURST_BEATS = 16
) (
    input  logic       aclk,
    input  logic       arst_n,
    input  dma_desc_t  desc,
    input  logic       desc_valid,
    output logic       desc_ready,
    output burst_cmd_t cmd,
    output logic       cmd_valid,
    input  logic       cmd_ready,
    input  logic       burst_done,
    input  axi_resp_t  burst_resp,
    output logic       irq,
    input  logic       irq_w1c,
    output axi_resp_t  err
);

    // Beat offset inside the burst window
    localparam dma_len_t WIN_MASK = dma_len_t'(BURST_BEATS - 1);

    split_state_t state;
    addr_t        cur_addr;
    dma_len_t     rem_beats;
    dma_len_t     issued_cnt;
    dma_len_t     done_cnt;
    axi_resp_t    err_q;

    dma_len_t     win_off;
    dma_len_t     to_bound;
    dma_len_t     beats_now;
    logic         desc_hs;
    logic         cmd_hs;
    logic         last_cmd;

    assign desc_ready = (state == SPLIT_IDLE);
    assign cmd_valid  = (state == SPLIT_ISSUE);
    assign irq        = (state == SPLIT_IRQ);
    assign err        = err_q;

    assign desc_hs = desc_valid & desc_ready;
    assign cmd_hs  = cmd_valid & cmd_ready;

    // Beats left before the next window boundary
    assign win_off   = dma_len_t'(cur_addr >> BEAT_BYTES_LOG) & WIN_MASK;
    assign to_bound  = dma_len_t'(BURST_BEATS) - win_off;
    // Nearer of boundary and transfer end
    assign beats_now = (rem_beats < to_bound) ? rem_beats : to_bound;
    assign last_cmd  = (rem_beats == beats_now);

    // Held while cmd_valid waits, cur_addr only moves on handshake
    assign cmd = '{addr: cur_addr, len: axlen_t'(beats_now - 1'b1)};

    // Walk address and remaining beats
    always_ff @(posedge aclk) begin
        if (desc_hs) begin
            cur_addr  <= desc.addr;
            rem_beats <= desc.len >> BEAT_BYTES_LOG;
        end else if (cmd_hs) begin
            cur_addr  <= cur_addr + addr_t'(beats_now << BEAT_BYTES_LOG);
            rem_beats <= rem_beats - beats_now;
        end
    end

    // Burst bookkeeping and first error
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            issued_cnt <= '0;
            done_cnt   <= '0;
            err_q      <= OKAY;
        end else if (desc_hs) begin
            issued_cnt <= '0;
            done_cnt   <= '0;
            err_q      <= OKAY;
        end else begin
            if (cmd_hs) begin
                issued_cnt <= issued_cnt + 1'b1;
            end
            if (burst_done) begin
                done_cnt <= done_cnt + 1'b1;
                // Keep only the first bad response
                if (err_q == OKAY && burst_resp != OKAY) begin
                    err_q <= burst_resp;
                end
            end
        end
    end

    // Main FSM
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= SPLIT_IDLE;
        end else begin
            case (state)
                SPLIT_IDLE: begin
                    if (desc_hs) begin
                        state <= SPLIT_ISSUE;
                    end
                end
                SPLIT_ISSUE: begin
                    // Last command out, wait for its B
                    if (cmd_hs && last_cmd) begin
                        state <= SPLIT_DRAIN;
                    end
                end
                SPLIT_DRAIN: begin
                    if (burst_done && (done_cnt + 1'b1 == issued_cnt)) begin
                        state <= SPLIT_IRQ;
                    end
                end
                SPLIT_IRQ: begin
                    if (irq_w1c) begin
                        state <= SPLIT_IDLE;
                    end
                end
                default: state <= SPLIT_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== dma_pkg.sv ====
/*
  Shared widths, types and encodings of the DMA write path.
  Data bus is fixed at 32 bits, so one beat moves 4 bytes.
  axi_aw_t follows the AXI4 field widths (3-bit size, 2-bit burst).
  Every burst carries the single ID DMA_ID.
*/
`default_nettype none

package dma_pkg;

    // Bus widths
    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int STRB_W         = DATA_W / 8;
    localparam int ID_W           = 4;
    localparam int LEN_W          = 8;
    localparam int BEAT_BYTES_LOG = $clog2(STRB_W);

    // Fixed transaction ID for all DMA bursts
    localparam logic [ID_W-1:0] DMA_ID = 4'd1;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    // AXI len, beats minus one
    typedef logic [LEN_W-1:0]  axlen_t;
    // Transfer length in bytes
    typedef logic [31:0]       dma_len_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    typedef enum logic [1:0] {SPLIT_IDLE, SPLIT_ISSUE, SPLIT_DRAIN, SPLIT_IRQ} split_state_t;
    typedef enum logic [1:0] {WM_IDLE, WM_ADDR, WM_DATA} wm_state_t;

    typedef struct packed {
        addr_t    addr;
        dma_len_t len;
    } dma_desc_t;

    typedef struct packed {
        addr_t  addr;
        axlen_t len;
    } burst_cmd_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        addr_t           addr;
        axlen_t          len;
        logic [2:0]      size;
        logic [1:0]      burst;
    } axi_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        axi_resp_t       resp;
    } axi_b_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } usr_beat_t;

endpackage

`default_nettype wire

// ==== dma_write_top.sv ====
/*
  DMA write path: descriptor in, AXI4 write bursts out.
  One clock domain; read path and sideband signals are not provided.
  Send exactly desc.len bytes of user beats for each descriptor.
  irq marks the end of a transfer and err holds its first bad response.
*/
`timescale 1ns/1ps
`default_nettype none

module dma_write_top import dma_pkg::*; #(
    parameter int BURST_BEATS     = 16,
    parameter int FIFO_DEPTH      = 4,
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic      aclk,
    input  logic      arst_n,
    // Descriptor
    input  dma_desc_t desc,
    input  logic      desc_valid,
    output logic      desc_ready,
    // User write data
    input  usr_beat_t usr_w,
    input  logic      usr_wvalid,
    output logic      usr_wready,
    // AXI write channels
    output axi_aw_t   aw,
    output logic      awvalid,
    input  logic      awready,
    output axi_w_t    w,
    output logic      wvalid,
    input  logic      wready,
    input  axi_b_t    b,
    input  logic      bvalid,
    output logic      bready,
    // Completion
    output logic      irq,
    input  logic      irq_w1c,
    output axi_resp_t err
);

    // Splitter to FIFO
    burst_cmd_t cmd;
    logic       cmd_valid;
    logic       cmd_ready;
    // FIFO to master
    burst_cmd_t q_cmd;
    logic       q_valid;
    logic       q_ready;
    // Master back to splitter
    logic       burst_done;
    axi_resp_t  burst_resp;

    burst_splitter #(
        .BURST_BEATS (BURST_BEATS)
    ) u_splitter (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .desc       (desc),
        .desc_valid (desc_valid),
        .desc_ready (desc_ready),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .burst_done (burst_done),
        .burst_resp (burst_resp),
        .irq        (irq),
        .irq_w1c    (irq_w1c),
        .err        (err)
    );

    burst_cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .wr_cmd   (cmd),
        .wr_valid (cmd_valid),
        .wr_ready (cmd_ready),
        .rd_cmd   (q_cmd),
        .rd_valid (q_valid),
        .rd_ready (q_ready)
    );

    axi_write_master #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_master (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .q_cmd      (q_cmd),
        .q_valid    (q_valid),
        .q_ready    (q_ready),
        .usr_w      (usr_w),
        .usr_wvalid (usr_wvalid),
        .usr_wready (usr_wready),
        .aw         (aw),
        .awvalid    (awvalid),
        .awready    (awready),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready),
        .b          (b),
        .bvalid     (bvalid),
        .bready     (bready),
        .burst_done (burst_done),
        .burst_resp (burst_resp)
    );

endmodule

`default_nettype wire

// ==== files.f ====
dma_pkg.sv
burst_splitter.sv
burst_cmd_fifo.sv
axi_write_master.sv
dma_write_top.sv
tb_axi_slave.sv
tb_dma_write.sv

// ==== tb_axi_slave.sv ====
/*
  AXI4 write slave model for the DMA testbench.
  Memory covers 4 KB; address bits above 11 are ignored.
  A burst that touches [err_lo, err_hi] answers SLVERR while err_en is high.
  stall_en adds random gaps on awready, wready and bvalid.
  Strobes are logged but not applied, every W beat writes a full word.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_axi_slave import dma_pkg::*; (
    input  logic    aclk,
    input  logic    arst_n,
    input  logic    stall_en,
    input  logic    err_en,
    input  addr_t   err_lo,
    input  addr_t   err_hi,
    input  axi_aw_t aw,
    input  logic    awvalid,
    output logic    awready,
    input  axi_w_t  w,
    input  logic    wvalid,
    output logic    wready,
    output axi_b_t  b,
    output logic    bvalid,
    input  logic    bready
);

    localparam int MEM_WORDS = 1024;

    data_t           mem [MEM_WORDS];
    // Every accepted AW, in order
    axi_aw_t         aw_log [$];
    // Strobe of every accepted W beat, in order
    strb_t           strb_log [$];
    axi_b_t          b_q [$];
    int              wlast_cnt;
    int              beat_cnt;
    int              last_err;

    // Burst in progress on W
    addr_t           wr_addr;
    axlen_t          wr_len;
    axlen_t          wr_idx;
    logic [ID_W-1:0] wr_id;
    logic            wr_bad;
    addr_t           burst_end;
    axi_b_t          b_next;

    // Fill word is the inverted byte address
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = ~data_t'(i * STRB_W);
        end
    end

    // Last byte touched by the burst on AW
    assign burst_end = aw.addr + (addr_t'(aw.len) << BEAT_BYTES_LOG) + addr_t'(STRB_W - 1);

    always @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            b         <= '0;
            wr_addr   <= '0;
            wr_len    <= '0;
            wr_idx    <= '0;
            wr_id     <= '0;
            wr_bad    <= 1'b0;
            wlast_cnt <= 0;
            beat_cnt  <= 0;
            last_err  <= 0;
        end else begin
            awready <= !stall_en || ($urandom_range(3) != 0);
            wready  <= !stall_en || ($urandom_range(3) != 0);

            if (awvalid && awready) begin
                aw_log.push_back(aw);
                wr_addr <= aw.addr;
                wr_len  <= aw.len;
                wr_idx  <= '0;
                wr_id   <= aw.id;
                // Any overlap with the window fails the whole burst
                wr_bad  <= err_en && (aw.addr <= err_hi) && (burst_end >= err_lo);
            end

            if (wvalid && wready) begin
                mem[wr_addr[11:2]] = w.data;
                strb_log.push_back(w.strb);
                wr_addr  <= wr_addr + addr_t'(STRB_W);
                wr_idx   <= wr_idx + 1'b1;
                beat_cnt <= beat_cnt + 1;
                // WLAST must sit on beat len exactly
                if (w.last != (wr_idx == wr_len)) begin
                    last_err <= last_err + 1;
                end
                if (w.last) begin
                    wlast_cnt   <= wlast_cnt + 1;
                    b_next.id   = wr_id;
                    b_next.resp = wr_bad ? SLVERR : OKAY;
                    b_q.push_back(b_next);
                end
            end

            // B payload held until accepted
            if (!bvalid || bready) begin
                if (b_q.size() != 0 && (!stall_en || $urandom_range(3) != 0)) begin
                    b      <= b_q.pop_front();
                    bvalid <= 1'b1;
                end else begin
                    bvalid <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_dma_write.sv ====
/*
  Directed testbench for dma_write_top with an AXI slave model.
  User beats carry data and strobes derived from their byte address.
  Expected burst layout is rebuilt from the window splitting rule.
  Addresses of all tests stay inside the slave's 4 KB memory.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_dma_write import dma_pkg::*; ();

    localparam int BURST_BEATS     = 16;
    localparam int FIFO_DEPTH      = 4;
    localparam int MAX_OUTSTANDING = 4;
    // Sum of beats over all tests
    localparam int TOTAL_BEATS     = 4 + 40 + 30 + 40 + 24;
    localparam int TIMEOUT_CYCLES  = 20 * TOTAL_BEATS + 1000;

    logic      aclk;
    logic      arst_n;
    dma_desc_t desc;
    logic      desc_valid;
    logic      desc_ready;
    usr_beat_t usr_w;
    logic      usr_wvalid;
    logic      usr_wready;
    axi_aw_t   aw;
    logic      awvalid;
    logic      awready;
    axi_w_t    w;
    logic      wvalid;
    logic      wready;
    axi_b_t    b;
    logic      bvalid;
    logic      bready;
    logic      irq;
    logic      irq_w1c;
    axi_resp_t err;

    // Slave configuration
    logic      stall_en;
    logic      err_en;
    addr_t     err_lo;
    addr_t     err_hi;

    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;
    addr_t     exp_addr [$];
    axlen_t    exp_len [$];

    dma_write_top #(
        .BURST_BEATS     (BURST_BEATS),
        .FIFO_DEPTH      (FIFO_DEPTH),
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) UUT (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .desc       (desc),
        .desc_valid (desc_valid),
        .desc_ready (desc_ready),
        .usr_w      (usr_w),
        .usr_wvalid (usr_wvalid),
        .usr_wready (usr_wready),
        .aw         (aw),
        .awvalid    (awvalid),
        .awready    (awready),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready),
        .b          (b),
        .bvalid     (bvalid),
        .bready     (bready),
        .irq        (irq),
        .irq_w1c    (irq_w1c),
        .err        (err)
    );

    tb_axi_slave u_slave (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .stall_en (stall_en),
        .err_en   (err_en),
        .err_lo   (err_lo),
        .err_hi   (err_hi),
        .aw       (aw),
        .awvalid  (awvalid),
        .awready  (awready),
        .w        (w),
        .wvalid   (wvalid),
        .wready   (wready),
        .b        (b),
        .bvalid   (bvalid),
        .bready   (bready)
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // Run limit
    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles, errors so far %0d",
                     cycles, errors);
            $display("Something failed");
            $finish;
        end
    end

    function automatic data_t beat_data(input addr_t a);
        return data_t'(a) ^ 32'hC0DE_0000;
    endfunction

    // Byte enables vary with the address, never all zero
    function automatic strb_t beat_strb(input addr_t a);
        return strb_t'(a >> BEAT_BYTES_LOG) | strb_t'(1);
    endfunction

    // Untouched slave words hold the inverted address
    function automatic data_t fill_word(input addr_t a);
        return ~data_t'(a);
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_strb(input string name, input strb_t got, input strb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_len(input string name, input axlen_t got, input axlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Small AW attribute fields: id, size, burst
    task automatic check_field(input string name, input logic [3:0] got,
                               input logic [3:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Bursts end at the nearer of window boundary and transfer end
    task automatic plan_bursts(input addr_t start, input int beats);
        addr_t a;
        int    left;
        int    room;
        int    n;
        exp_addr.delete();
        exp_len.delete();
        a    = start;
        left = beats;
        while (left > 0) begin
            room = BURST_BEATS - (int'(a >> BEAT_BYTES_LOG) % BURST_BEATS);
            n    = (left < room) ? left : room;
            exp_addr.push_back(a);
            exp_len.push_back(axlen_t'(n - 1));
            a    = a + addr_t'(n * STRB_W);
            left = left - n;
        end
    endtask

    // One descriptor end to end, then check and clear
    task automatic run_transfer(input addr_t start, input int beats, input logic stalls,
                                input logic err_win, input axi_resp_t exp_err);
        int    log_base;
        int    last_base;
        int    beat_base;
        int    strb_base;
        int    sent;
        logic  hs;
        addr_t a;
        plan_bursts(start, beats);
        @(posedge aclk);
        stall_en <= stalls;
        err_en   <= err_win;
        @(negedge aclk);
        log_base  = u_slave.aw_log.size();
        last_base = u_slave.wlast_cnt;
        beat_base = u_slave.beat_cnt;
        strb_base = u_slave.strb_log.size();
        check_flag("desc_ready before descriptor", desc_ready, 1'b1);

        @(posedge aclk);
        desc       <= '{addr: start, len: dma_len_t'(beats * STRB_W)};
        desc_valid <= 1'b1;
        @(posedge aclk);
        desc_valid <= 1'b0;

        // Valid is held until accepted, gaps only between beats
        sent = 0;
        while (sent < beats) begin
            @(negedge aclk);
            hs = usr_wvalid && usr_wready;
            @(posedge aclk);
            if (hs) begin
                sent++;
            end
            if (hs || !usr_wvalid) begin
                if (sent < beats && !(stalls && $urandom_range(3) == 0)) begin
                    a = start + addr_t'(sent * STRB_W);
                    usr_w      <= '{data: beat_data(a), strb: beat_strb(a)};
                    usr_wvalid <= 1'b1;
                end else begin
                    usr_wvalid <= 1'b0;
                end
            end
        end

        @(negedge aclk);
        while (!irq) begin
            @(negedge aclk);
        end
        check_resp("err", err, exp_err);
        // irq and err hold, no new descriptor taken
        repeat (3) begin
            @(negedge aclk);
            check_flag("irq held", irq, 1'b1);
            check_flag("desc_ready while irq", desc_ready, 1'b0);
            check_resp("err held", err, exp_err);
        end

        check_count("aw count", u_slave.aw_log.size() - log_base, exp_addr.size());
        for (int k = 0; k < exp_addr.size() && log_base + k < u_slave.aw_log.size(); k++) begin
            check_addr("awaddr", u_slave.aw_log[log_base + k].addr, exp_addr[k]);
            check_len("awlen", u_slave.aw_log[log_base + k].len, exp_len[k]);
            // Fixed ID, full 4-byte beats, INCR
            check_field("awid", u_slave.aw_log[log_base + k].id, DMA_ID);
            check_field("awsize", 4'(u_slave.aw_log[log_base + k].size), 4'd2);
            check_field("awburst", 4'(u_slave.aw_log[log_base + k].burst), 4'd1);
        end
        check_count("wlast count", u_slave.wlast_cnt - last_base, exp_addr.size());
        check_count("w beats", u_slave.beat_cnt - beat_base, beats);
        check_count("misplaced wlast", u_slave.last_err, 0);

        for (int k = 0; k < beats; k++) begin
            a = start + addr_t'(k * STRB_W);
            check_data("mem", u_slave.mem[a[11:2]], beat_data(a));
            if (strb_base + k < u_slave.strb_log.size()) begin
                check_strb("wstrb", u_slave.strb_log[strb_base + k], beat_strb(a));
            end
        end
        // Word after the transfer untouched
        a = start + addr_t'(beats * STRB_W);
        check_data("mem past end", u_slave.mem[a[11:2]], fill_word(a));

        @(posedge aclk);
        irq_w1c <= 1'b1;
        @(posedge aclk);
        irq_w1c <= 1'b0;
        @(negedge aclk);
        check_flag("irq after w1c", irq, 1'b0);
        check_flag("desc_ready after w1c", desc_ready, 1'b1);
    endtask

    task automatic check_reset_state();
        @(negedge aclk);
        check_flag("desc_ready", desc_ready, 1'b1);
        check_flag("irq", irq, 1'b0);
        check_flag("awvalid", awvalid, 1'b0);
        check_flag("wvalid", wvalid, 1'b0);
        check_flag("bready", bready, 1'b1);
        check_resp("err", err, OKAY);
    endtask

    task automatic test_single_burst();
        run_transfer(32'h0000_0000, 4, 1'b0, 1'b0, OKAY);
    endtask

    task automatic test_multi_burst();
        run_transfer(32'h0000_0100, 40, 1'b0, 1'b0, OKAY);
    endtask

    // Beat 9 of a window, first burst cut to 7 beats
    task automatic test_unaligned_start();
        run_transfer(32'h0000_0224, 30, 1'b0, 1'b0, OKAY);
    endtask

    task automatic test_random_stalls();
        run_transfer(32'h0000_0400, 40, 1'b1, 1'b0, OKAY);
    endtask

    // Second burst falls in the window
    task automatic test_error_response();
        @(posedge aclk);
        err_lo <= 32'h0000_0640;
        err_hi <= 32'h0000_067F;
        run_transfer(32'h0000_0600, 24, 1'b0, 1'b1, SLVERR);
    endtask

    initial begin
        void'($urandom(62052));
        arst_n     <= 1'b0;
        desc       <= '0;
        desc_valid <= 1'b0;
        usr_w      <= '0;
        usr_wvalid <= 1'b0;
        irq_w1c    <= 1'b0;
        stall_en   <= 1'b0;
        err_en     <= 1'b0;
        err_lo     <= '0;
        err_hi     <= '0;
        repeat (8) @(posedge aclk);
        arst_n <= 1'b1;

        check_reset_state();
        test_single_burst();
        test_multi_burst();
        test_unaligned_start();
        test_random_stalls();
        test_error_response();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
